// File: rtl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data and address width
`define XLEN 32

// architectural register file
`define NUM_REGS 32
`define REG_AW $clog2(`NUM_REGS)

// internal data RAM depth in words
`define DMEM_WORDS 64

`define RESET_PC 32'h0000_0000

`endif

// File: rtl/core_pkg.sv
package core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_type_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    // source of the register write value
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

endpackage

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module inst_decoder import core_pkg::*; (
    input  logic [31:0]        inst_i,
    output alu_op_e            alu_op_o,
    output op2_sel_e           op2_sel_o,
    output br_type_e           br_type_o,
    output wb_sel_e            wb_sel_o,
    output logic               rf_wen_o,
    output logic               mem_wen_o,
    output logic               halt_o,
    output logic [`REG_AW-1:0] rd_o,
    output logic [`REG_AW-1:0] rs1_o,
    output logic [`REG_AW-1:0] rs2_o,
    output logic [`XLEN-1:0]   imm_o
);

    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             wen;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign imm_j = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // x0 as destination never writes
    assign rf_wen_o = wen && (rd_o != '0);

    always_comb begin
        alu_op_o  = ALU_ADD;
        op2_sel_o = OP2_RS2;
        br_type_o = BR_NONE;
        wb_sel_o  = WB_ALU;
        wen       = 1'b0;
        mem_wen_o = 1'b0;
        halt_o    = 1'b0;
        imm_o     = imm_i;
        case (inst_i[6:0])
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    wen = 1'b1;
                    case (funct3)
                        3'b000: alu_op_o = ALU_ADD;
                        3'b010: alu_op_o = ALU_SLT;
                        3'b100: alu_op_o = ALU_XOR;
                        3'b110: alu_op_o = ALU_OR;
                        3'b111: alu_op_o = ALU_AND;
                        default: wen = 1'b0;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    wen      = 1'b1;
                    alu_op_o = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                op2_sel_o = OP2_IMM;
                wen       = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    default: wen = 1'b0;
                endcase
            end
            OPC_LUI: begin
                alu_op_o  = ALU_PASS_B;
                op2_sel_o = OP2_IMM;
                imm_o     = imm_u;
                wen       = 1'b1;
            end
            OPC_LOAD: begin
                op2_sel_o = OP2_IMM;
                wb_sel_o  = WB_MEM;
                wen       = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                op2_sel_o = OP2_IMM;
                imm_o     = imm_s;
                mem_wen_o = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                imm_o = imm_b;
                if (funct3 == 3'b000) begin
                    br_type_o = BR_EQ;
                end else if (funct3 == 3'b001) begin
                    br_type_o = BR_NE;
                end
            end
            OPC_JAL: begin
                br_type_o = BR_JAL;
                wb_sel_o  = WB_PC4;
                imm_o     = imm_j;
                wen       = 1'b1;
            end
            OPC_SYSTEM: begin
                // ebreak only
                halt_o = (inst_i[31:7] == 25'h0002000);
            end
            default: begin
                wen = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module operand_select (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic [`REG_AW-1:0] rs1_i,
    input  logic [`REG_AW-1:0] rs2_i,
    input  logic               ds_valid_i,
    input  logic               exe_wen_i,
    input  logic [`REG_AW-1:0] exe_rd_i,
    input  logic               mem_wen_i,
    input  logic               mem_fwd_ok_i,
    input  logic [`REG_AW-1:0] mem_rd_i,
    input  logic [`XLEN-1:0]   mem_value_i,
    input  logic               wb_wen_i,
    input  logic [`REG_AW-1:0] wb_rd_i,
    input  logic [`XLEN-1:0]   wb_value_i,
    output logic [`XLEN-1:0]   op1_o,
    output logic [`XLEN-1:0]   op2_raw_o,
    output logic               ds_stall_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // memory forward first, then writeback, then the file
    function automatic logic [`XLEN-1:0] read_src(input logic [`REG_AW-1:0] rs);
        logic [`XLEN-1:0] val;
        if (rs == '0) begin
            val = '0;
        end else if (mem_wen_i && mem_fwd_ok_i && mem_rd_i == rs) begin
            val = mem_value_i;
        end else if (wb_wen_i && wb_rd_i == rs) begin
            val = wb_value_i;
        end else begin
            val = regs[rs];
        end
        return val;
    endfunction

    // execute never forwards, a load in memory cannot yet
    function automatic logic src_hazard(input logic [`REG_AW-1:0] rs);
        logic hit;
        hit = (rs != '0) &&
              ((exe_wen_i && exe_rd_i == rs) ||
               (mem_wen_i && !mem_fwd_ok_i && mem_rd_i == rs));
        return hit;
    endfunction

    always_comb begin
        op1_o      = read_src(rs1_i);
        op2_raw_o  = read_src(rs2_i);
        ds_stall_o = ds_valid_i && (src_hazard(rs1_i) || src_hazard(rs2_i));
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_value_i;
        end
    end

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_unit import core_pkg::*; (
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] op1_i,
    input  logic [`XLEN-1:0] op2_i,
    input  alu_op_e          alu_op_i,
    input  br_type_e         br_type_i,
    input  logic [`XLEN-1:0] imm_i,
    output logic [`XLEN-1:0] alu_result_o,
    output logic             br_taken_o,
    output logic [`XLEN-1:0] br_target_o
);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_result_o = op1_i + op2_i;
            ALU_SUB:    alu_result_o = op1_i - op2_i;
            ALU_AND:    alu_result_o = op1_i & op2_i;
            ALU_OR:     alu_result_o = op1_i | op2_i;
            ALU_XOR:    alu_result_o = op1_i ^ op2_i;
            ALU_SLT:    alu_result_o = {{(`XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_PASS_B: alu_result_o = op2_i;
            default:    alu_result_o = '0;
        endcase
    end

    // branches compare rs1 against rs2
    always_comb begin
        case (br_type_i)
            BR_EQ:   br_taken_o = (op1_i == op2_i);
            BR_NE:   br_taken_o = (op1_i != op2_i);
            BR_JAL:  br_taken_o = 1'b1;
            default: br_taken_o = 1'b0;
        endcase
    end

    assign br_target_o = pc_i + imm_i;

endmodule

// File: rtl/mem_access_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module mem_access_stage (
    input  logic             clk,
    input  logic             valid_i,
    input  logic             mem_wen_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic [`XLEN-1:0] rdata_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] ram [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    // word address, wraps at the RAM depth
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (valid_i && mem_wen_i) begin
            ram[idx] <= wdata_i;
        end
    end

    // asynchronous read, result is registered in writeback
    assign rdata_o = ram[idx];

endmodule

// File: rtl/pipe_core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module pipe_core import core_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic [31:0]        imem_data_i,
    output logic [`XLEN-1:0]   imem_addr_o,
    output logic               retire_valid_o,
    output logic [`XLEN-1:0]   retire_pc_o,
    output logic [`REG_AW-1:0] retire_rd_o,
    output logic               retire_wen_o,
    output logic [`XLEN-1:0]   retire_wdata_o,
    output logic               exit_o
);

    logic [`XLEN-1:0] pc_q, redirect_target_q;
    logic             redirect_now, redirect_q;
    logic             halt_now, halt_q, kill, exit_q;
    logic             ds_stall;

    // decode stage
    logic               id_valid;
    logic [`XLEN-1:0]   id_pc, id_imm;
    logic [31:0]        id_inst;
    alu_op_e            id_alu_op;
    op2_sel_e           id_op2_sel;
    br_type_e           id_br_type;
    wb_sel_e            id_wb_sel;
    logic               id_rf_wen, id_mem_wen, id_halt;
    logic [`REG_AW-1:0] id_rd, id_rs1, id_rs2;

    // data select stage
    logic               ds_valid;
    logic [`XLEN-1:0]   ds_pc, ds_imm, ds_op1, ds_op2_raw;
    alu_op_e            ds_alu_op;
    op2_sel_e           ds_op2_sel;
    br_type_e           ds_br_type;
    wb_sel_e            ds_wb_sel;
    logic               ds_rf_wen, ds_mem_wen, ds_halt;
    logic [`REG_AW-1:0] ds_rd, ds_rs1, ds_rs2;

    // execute stage
    logic               exe_valid;
    logic [`XLEN-1:0]   exe_pc, exe_imm, exe_op1, exe_op2, exe_store_data;
    logic [`XLEN-1:0]   exe_alu_result, exe_br_target;
    alu_op_e            exe_alu_op;
    br_type_e           exe_br_type;
    wb_sel_e            exe_wb_sel;
    logic               exe_rf_wen, exe_mem_wen, exe_halt, exe_br_taken;
    logic [`REG_AW-1:0] exe_rd;

    // memory and writeback stages
    logic               mem_valid, mem_rf_wen, mem_mem_wen, mem_halt;
    logic [`XLEN-1:0]   mem_pc, mem_alu_out, mem_store_data, mem_rdata, mem_value;
    wb_sel_e            mem_wb_sel;
    logic [`REG_AW-1:0] mem_rd;
    logic               wb_valid, wb_rf_wen, wb_halt;
    logic [`XLEN-1:0]   wb_pc, wb_alu_out, wb_mem_rdata, wb_wdata;
    wb_sel_e            wb_wb_sel;
    logic [`REG_AW-1:0] wb_rd;

    assign redirect_now = exe_valid && exe_br_taken;
    assign halt_now     = exe_valid && exe_halt;
    assign kill         = halt_now || halt_q;
    assign imem_addr_o  = pc_q;

    // fetch, registered redirect and sticky halt
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= `RESET_PC;
            redirect_q <= 1'b0;
            halt_q     <= 1'b0;
            exit_q     <= 1'b0;
        end else begin
            redirect_q <= redirect_now;
            halt_q     <= kill;
            exit_q     <= exit_q || (wb_valid && wb_halt);
            if (redirect_q) begin
                pc_q <= redirect_target_q;
            end else if (!kill && !ds_stall) begin
                pc_q <= pc_q + 'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        redirect_target_q <= exe_br_target;
    end

    // stage valids
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid  <= 1'b0;
            ds_valid  <= 1'b0;
            exe_valid <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (redirect_now || redirect_q || kill) begin
                id_valid <= 1'b0;
            end else if (!ds_stall) begin
                id_valid <= 1'b1;
            end
            if (redirect_now || kill) begin
                ds_valid <= 1'b0;
            end else if (!ds_stall) begin
                ds_valid <= id_valid;
            end
            // stall leaves a bubble in execute
            exe_valid <= ds_valid && !ds_stall && !redirect_now && !kill;
            mem_valid <= exe_valid;
            wb_valid  <= mem_valid;
        end
    end

    // stage payloads
    always_ff @(posedge clk) begin
        if (!ds_stall) begin
            id_pc      <= pc_q;
            id_inst    <= imem_data_i;
            ds_pc      <= id_pc;
            ds_imm     <= id_imm;
            ds_alu_op  <= id_alu_op;
            ds_op2_sel <= id_op2_sel;
            ds_br_type <= id_br_type;
            ds_wb_sel  <= id_wb_sel;
            ds_rf_wen  <= id_rf_wen;
            ds_mem_wen <= id_mem_wen;
            ds_halt    <= id_halt;
            ds_rd      <= id_rd;
            ds_rs1     <= id_rs1;
            ds_rs2     <= id_rs2;
        end
        exe_pc         <= ds_pc;
        exe_imm        <= ds_imm;
        exe_op1        <= ds_op1;
        exe_op2        <= (ds_op2_sel == OP2_IMM) ? ds_imm : ds_op2_raw;
        exe_store_data <= ds_op2_raw;
        exe_alu_op     <= ds_alu_op;
        exe_br_type    <= ds_br_type;
        exe_wb_sel     <= ds_wb_sel;
        exe_rf_wen     <= ds_rf_wen;
        exe_mem_wen    <= ds_mem_wen;
        exe_halt       <= ds_halt;
        exe_rd         <= ds_rd;
        mem_pc         <= exe_pc;
        mem_alu_out    <= exe_alu_result;
        mem_store_data <= exe_store_data;
        mem_wb_sel     <= exe_wb_sel;
        mem_rf_wen     <= exe_rf_wen;
        mem_mem_wen    <= exe_mem_wen;
        mem_halt       <= exe_halt;
        mem_rd         <= exe_rd;
        wb_pc          <= mem_pc;
        wb_alu_out     <= mem_alu_out;
        wb_mem_rdata   <= mem_rdata;
        wb_wb_sel      <= mem_wb_sel;
        wb_rf_wen      <= mem_rf_wen;
        wb_halt        <= mem_halt;
        wb_rd          <= mem_rd;
    end

    inst_decoder u_inst_decoder (
        .inst_i    (id_inst),
        .alu_op_o  (id_alu_op),
        .op2_sel_o (id_op2_sel),
        .br_type_o (id_br_type),
        .wb_sel_o  (id_wb_sel),
        .rf_wen_o  (id_rf_wen),
        .mem_wen_o (id_mem_wen),
        .halt_o    (id_halt),
        .rd_o      (id_rd),
        .rs1_o     (id_rs1),
        .rs2_o     (id_rs2),
        .imm_o     (id_imm)
    );

    // link value forwards from memory like any ALU result
    assign mem_value = (mem_wb_sel == WB_PC4) ? mem_pc + 'd4 : mem_alu_out;

    operand_select u_operand_select (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .rs1_i        (ds_rs1),
        .rs2_i        (ds_rs2),
        .ds_valid_i   (ds_valid),
        .exe_wen_i    (exe_valid && exe_rf_wen),
        .exe_rd_i     (exe_rd),
        .mem_wen_i    (mem_valid && mem_rf_wen),
        .mem_fwd_ok_i (mem_wb_sel != WB_MEM),
        .mem_rd_i     (mem_rd),
        .mem_value_i  (mem_value),
        .wb_wen_i     (wb_valid && wb_rf_wen),
        .wb_rd_i      (wb_rd),
        .wb_value_i   (wb_wdata),
        .op1_o        (ds_op1),
        .op2_raw_o    (ds_op2_raw),
        .ds_stall_o   (ds_stall)
    );

    execute_unit u_execute_unit (
        .pc_i         (exe_pc),
        .op1_i        (exe_op1),
        .op2_i        (exe_op2),
        .alu_op_i     (exe_alu_op),
        .br_type_i    (exe_br_type),
        .imm_i        (exe_imm),
        .alu_result_o (exe_alu_result),
        .br_taken_o   (exe_br_taken),
        .br_target_o  (exe_br_target)
    );

    mem_access_stage u_mem_access_stage (
        .clk       (clk),
        .valid_i   (mem_valid),
        .mem_wen_i (mem_mem_wen),
        .addr_i    (mem_alu_out),
        .wdata_i   (mem_store_data),
        .rdata_o   (mem_rdata)
    );

    always_comb begin
        case (wb_wb_sel)
            WB_MEM:  wb_wdata = wb_mem_rdata;
            WB_PC4:  wb_wdata = wb_pc + 'd4;
            default: wb_wdata = wb_alu_out;
        endcase
    end

    assign retire_valid_o = wb_valid;
    assign retire_pc_o    = wb_pc;
    assign retire_rd_o    = wb_rd;
    assign retire_wen_o   = wb_valid && wb_rf_wen;
    assign retire_wdata_o = wb_wdata;
    assign exit_o         = exit_q;

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    // 8 ns period
    localparam real HALF_PERIOD = 4.0;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

// File: verif/pipe_core_chk.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module pipe_core_chk (
    input logic               clk,
    input logic               rst_n_i,
    input logic               retire_valid_i,
    input logic               retire_wen_i,
    input logic [`REG_AW-1:0] retire_rd_i,
    input logic               exit_i
);

    // exit is sticky until the next reset
    exit_sticky: assert property (@(posedge clk) disable iff (!rst_n_i) exit_i |=> exit_i)
        else $error("exit_o fell while out of reset");

    wen_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_wen_i |-> retire_rd_i != '0)
        else $error("register write retired with rd equal to zero");

    no_retire_after_exit: assert property (@(posedge clk) disable iff (!rst_n_i)
        exit_i |-> !retire_valid_i)
        else $error("instruction retired while exit_o was high");

endmodule

bind pipe_core pipe_core_chk u_pipe_core_chk (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .retire_valid_i (retire_valid_o),
    .retire_wen_i   (retire_wen_o),
    .retire_rd_i    (retire_rd_o),
    .exit_i         (exit_o)
);

// File: verif/pipe_core_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module pipe_core_tb import core_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_PROG   = 256;
    localparam int RAND_COUNT = 150;
    localparam int DM_AW      = $clog2(`DMEM_WORDS);

    // instruction kinds of the generator
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLT  = 5;
    localparam int K_ADDI = 6;
    localparam int K_ANDI = 7;
    localparam int K_ORI  = 8;
    localparam int K_XORI = 9;
    localparam int K_LUI  = 10;
    localparam int K_LW   = 11;
    localparam int K_SW   = 12;
    localparam int K_BEQ  = 13;
    localparam int K_BNE  = 14;
    localparam int K_JAL  = 15;
    localparam int K_HALT = 16;

    localparam int T_RESET = 0;
    localparam int T_ARITH = 1;
    localparam int T_HAZ   = 2;
    localparam int T_CTRL  = 3;
    localparam int T_MEM   = 4;
    localparam int T_HALT  = 5;
    localparam int N_TESTS = 6;

    logic               clk;
    logic               rst_n;
    logic [31:0]        imem_data;
    logic [`XLEN-1:0]   imem_addr;
    logic               retire_valid;
    logic [`XLEN-1:0]   retire_pc;
    logic [`REG_AW-1:0] retire_rd;
    logic               retire_wen;
    logic [`XLEN-1:0]   retire_wdata;
    logic               core_exit;

    logic [31:0] prog [MAX_PROG];
    int          kind_a [MAX_PROG];
    int          rd_a [MAX_PROG];
    int          rs1_a [MAX_PROG];
    int          rs2_a [MAX_PROG];
    int          imm_a [MAX_PROG];
    int          prog_len;
    int          prefix_len;

    // expected retire sequence from the ISA model
    logic [31:0] exp_pc [MAX_PROG];
    logic [31:0] exp_rd [MAX_PROG];
    logic [31:0] exp_wdata [MAX_PROG];
    logic        exp_wen [MAX_PROG];
    int          exp_cat [MAX_PROG];
    int          exp_len;

    int     ret_cnt;
    int     err [N_TESTS];
    int     nchk [N_TESTS];
    integer seed;
    bit     gen_done;

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    pipe_core u_pipe_core (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .imem_data_i    (imem_data),
        .imem_addr_o    (imem_addr),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_wen_o   (retire_wen),
        .retire_wdata_o (retire_wdata),
        .exit_o         (core_exit)
    );

    // past the end of the program every word is ebreak
    always_comb begin
        if (imem_addr[31:2] < 30'(prog_len)) begin
            imem_data = prog[imem_addr[9:2]];
        end else begin
            imem_data = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};
        end
    end

    function automatic int rnd(input int n);
        integer r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [31:0] encode(input int k, input int rd, input int rs1,
                                           input int rs2, input int imm);
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [31:0] v;
        logic [31:0] word;
        d  = rd[4:0];
        s1 = rs1[4:0];
        s2 = rs2[4:0];
        v  = imm;
        case (k)
            K_ADD:   word = {7'h00, s2, s1, 3'b000, d, OPC_OP};
            K_SUB:   word = {7'h20, s2, s1, 3'b000, d, OPC_OP};
            K_AND:   word = {7'h00, s2, s1, 3'b111, d, OPC_OP};
            K_OR:    word = {7'h00, s2, s1, 3'b110, d, OPC_OP};
            K_XOR:   word = {7'h00, s2, s1, 3'b100, d, OPC_OP};
            K_SLT:   word = {7'h00, s2, s1, 3'b010, d, OPC_OP};
            K_ADDI:  word = {v[11:0], s1, 3'b000, d, OPC_OP_IMM};
            K_ANDI:  word = {v[11:0], s1, 3'b111, d, OPC_OP_IMM};
            K_ORI:   word = {v[11:0], s1, 3'b110, d, OPC_OP_IMM};
            K_XORI:  word = {v[11:0], s1, 3'b100, d, OPC_OP_IMM};
            K_LUI:   word = {v[19:0], d, OPC_LUI};
            K_LW:    word = {v[11:0], s1, 3'b010, d, OPC_LOAD};
            K_SW:    word = {v[11:5], s2, s1, 3'b010, v[4:0], OPC_STORE};
            K_BEQ:   word = {v[12], v[10:5], s2, s1, 3'b000, v[4:1], v[11], OPC_BRANCH};
            K_BNE:   word = {v[12], v[10:5], s2, s1, 3'b001, v[4:1], v[11], OPC_BRANCH};
            K_JAL:   word = {v[20], v[10:1], v[11], v[19:12], d, OPC_JAL};
            default: word = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};
        endcase
        return word;
    endfunction

    task automatic emit(input int k, input int rd, input int rs1, input int rs2, input int imm);
        kind_a[prog_len] = k;
        rd_a[prog_len]   = rd;
        rs1_a[prog_len]  = rs1;
        rs2_a[prog_len]  = rs2;
        imm_a[prog_len]  = imm;
        prog[prog_len]   = encode(k, rd, rs1, rs2, imm);
        prog_len++;
    endtask

    task automatic build_prefix();
        emit(K_ADDI, 1, 0, 0, 5);
        // stalls on execute, then takes the memory forward
        emit(K_ADDI, 2, 1, 0, 3);
        emit(K_LUI, 3, 0, 0, 32'h12345);
        emit(K_SUB, 4, 2, 1, 0);
        emit(K_ADDI, 5, 0, 0, -9);
        emit(K_OR, 6, 3, 5, 0);
        emit(K_SLT, 7, 5, 1, 0);
        emit(K_AND, 1, 7, 6, 0);
        emit(K_XORI, 2, 1, 0, 1445);
        // every RAM slot gets a value before any load
        for (int s = 0; s < 8; s++) begin
            emit(K_SW, 0, 0, s, s * 32);
        end
        emit(K_LW, 2, 0, 0, 32);
        emit(K_ADD, 3, 2, 2, 0);
        emit(K_LW, 4, 0, 0, 96);
        emit(K_SW, 0, 0, 4, 64);
        emit(K_LW, 5, 0, 0, 64);
        emit(K_XOR, 6, 5, 4, 0);
        emit(K_JAL, 7, 0, 0, 8);
        emit(K_ADDI, 1, 0, 0, 1);
        emit(K_ADD, 2, 7, 0, 0);
        emit(K_BEQ, 0, 2, 2, 8);
        emit(K_ADDI, 3, 0, 0, 2);
        emit(K_BNE, 0, 2, 2, 8);
        emit(K_ADDI, 3, 0, 0, 3);
        prefix_len = prog_len;
    endtask

    task automatic build_random();
        int k;
        int rd;
        int rs1;
        int rs2;
        int slot;
        while (prog_len < prefix_len + RAND_COUNT) begin
            k   = rnd(16);
            rd  = rnd(8);
            rs1 = rnd(8);
            rs2 = rnd(8);
            if (k <= K_SLT) begin
                emit(k, rd, rs1, rs2, 0);
            end else if (k <= K_XORI) begin
                emit(k, rd, rs1, 0, rnd(4096) - 2048);
            end else if (k == K_LUI) begin
                emit(k, rd, 0, 0, rnd(1 << 20));
            end else if (k == K_LW || k == K_SW) begin
                slot = rnd(8);
                emit(K_SW, 0, 0, rs2, slot * 32);
                emit(K_LW, rd, 0, 0, slot * 32);
            end else if (k == K_JAL) begin
                emit(K_JAL, rd, 0, 0, 4 * (rnd(4) + 2));
            end else begin
                // skips 1 to 4 instructions when taken
                emit(k, 0, rs1, rs2, 4 * (rnd(4) + 2));
            end
        end
        emit(K_HALT, 0, 0, 0, 0);
    endtask

    function automatic int category(input int i, input int k);
        if (k == K_HALT) begin
            return T_HALT;
        end
        if (i < prefix_len) begin
            return T_HAZ;
        end
        if (k <= K_LUI) begin
            return T_ARITH;
        end
        if (k <= K_SW) begin
            return T_MEM;
        end
        return T_CTRL;
    endfunction

    task automatic run_model();
        logic [31:0]      mreg [32];
        logic [31:0]      mdm [`DMEM_WORDS];
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      imm;
        logic [31:0]      res;
        logic [31:0]      addr;
        logic [DM_AW-1:0] widx;
        logic             wr;
        int               i;
        int               k;
        int               nxt;
        for (int r = 0; r < 32; r++) begin
            mreg[r] = '0;
        end
        i       = 0;
        k       = K_ADD;
        exp_len = 0;
        while (k != K_HALT) begin
            k    = (i < prog_len) ? kind_a[i] : K_HALT;
            a    = mreg[rs1_a[i]];
            b    = mreg[rs2_a[i]];
            imm  = imm_a[i];
            addr = a + imm;
            widx = addr[DM_AW+1:2];
            res  = '0;
            wr   = 1'b1;
            nxt  = i + 1;
            case (k)
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: res = a + imm;
                K_ANDI: res = a & imm;
                K_ORI:  res = a | imm;
                K_XORI: res = a ^ imm;
                K_LUI:  res = imm << 12;
                K_LW:   res = mdm[widx];
                K_SW: begin
                    wr        = 1'b0;
                    mdm[widx] = b;
                end
                K_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nxt = i + imm_a[i] / 4;
                    end
                end
                K_BNE: begin
                    wr = 1'b0;
                    if (a != b) begin
                        nxt = i + imm_a[i] / 4;
                    end
                end
                K_JAL: begin
                    res = i * 4 + 4;
                    nxt = i + imm_a[i] / 4;
                end
                default: wr = 1'b0;
            endcase
            wr = wr && (rd_a[i] != 0);
            if (wr) begin
                mreg[rd_a[i]] = res;
            end
            exp_pc[exp_len]    = i * 4;
            exp_wen[exp_len]   = wr;
            exp_rd[exp_len]    = rd_a[i];
            exp_wdata[exp_len] = res;
            exp_cat[exp_len]   = category(i, k);
            exp_len++;
            i = nxt;
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            T_RESET: return "reset";
            T_ARITH: return "arithmetic";
            T_HAZ:   return "hazards";
            T_CTRL:  return "control_flow";
            T_MEM:   return "memory";
            default: return "halt";
        endcase
    endfunction

    task automatic check_val(input int t, input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
        nchk[t]++;
        assert (actv === expv) else begin
            $display("[FAIL] %s: %s of retire %0d, expected %h, actual %h",
                     test_name(t), what, ret_cnt, expv, actv);
            err[t]++;
        end
    endtask

    task automatic report_test(input int t);
        $display("%-12s %0d checks, %0d errors, %s", test_name(t), nchk[t], err[t],
                 (err[t] == 0) ? "ok" : "failing");
    endtask

    task automatic check_retire();
        int t;
        nchk[T_HALT]++;
        assert (ret_cnt < exp_len) else begin
            $display("instruction at pc %h retired after the halt", retire_pc);
            err[T_HALT]++;
            return;
        end
        t = exp_cat[ret_cnt];
        if (ret_cnt == 0) begin
            check_val(T_RESET, "first pc", 32'h0, retire_pc);
            report_test(T_RESET);
        end
        check_val(T_CTRL, "pc", exp_pc[ret_cnt], retire_pc);
        check_val(t, "wen", 32'(exp_wen[ret_cnt]), 32'(retire_wen));
        if (exp_wen[ret_cnt]) begin
            check_val(t, "rd", exp_rd[ret_cnt], 32'(retire_rd));
            check_val(t, "wdata", exp_wdata[ret_cnt], retire_wdata);
        end
        ret_cnt++;
    endtask

    // outputs are registered, so mid-cycle is stable
    always @(negedge clk) begin
        if (retire_valid === 1'b1) begin
            check_retire();
        end
    end

    initial begin
        wait (gen_done);
        #(20 * prog_len * CLK_PERIOD);
        $display("timeout: exit_o did not rise within %0d ns", 20 * prog_len * CLK_PERIOD);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int npass;
        int nerr;
        int ntot;
        rst_n    = 1'b0;
        seed     = 82;
        prog_len = 0;
        ret_cnt  = 0;
        gen_done = 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            err[t]  = 0;
            nchk[t] = 0;
        end
        build_prefix();
        build_random();
        run_model();
        gen_done = 1'b1;

        repeat (4) begin
            @(negedge clk);
            nchk[T_RESET]++;
            assert (retire_valid === 1'b0 && core_exit === 1'b0) else begin
                $display("retire_valid_o or exit_o was high during reset");
                err[T_RESET]++;
            end
        end
        rst_n = 1'b1;

        while (core_exit !== 1'b1) begin
            @(negedge clk);
        end
        check_val(T_HALT, "retire count", 32'(exp_len), 32'(ret_cnt));
        repeat (10) begin
            @(negedge clk);
            nchk[T_HALT]++;
            assert (core_exit === 1'b1) else begin
                $display("exit_o dropped after the halt retired");
                err[T_HALT]++;
            end
        end

        npass = 0;
        nerr  = 0;
        ntot  = 0;
        for (int t = 1; t < N_TESTS; t++) begin
            report_test(t);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            if (err[t] == 0) begin
                npass++;
            end
            nerr += err[t];
            ntot += nchk[t];
        end
        $display("summary: %0d of %0d tests passed, %0d checks, %0d errors",
                 npass, N_TESTS, ntot, nerr);
        if (nerr == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: pipe_core.f
+incdir+rtl
rtl/core_pkg.sv
rtl/inst_decoder.sv
rtl/operand_select.sv
rtl/execute_unit.sv
rtl/mem_access_stage.sv
rtl/pipe_core.sv
verif/tb_clk_gen.sv
verif/pipe_core_chk.sv
verif/pipe_core_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := pipe_core_tb
FILELIST := pipe_core.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "Simulation FAILED" $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
